/* hdl/align_pkg.sv */
package align_pkg;

    // Byte addresses, lengths and beat counts share one width
    localparam int LEN_W = 16;

    typedef logic [LEN_W-1:0] byte_len_t;   // Byte address or byte length
    typedef logic [LEN_W-1:0] beat_cnt_t;   // Beat or word count

    // Decode machine states
    typedef enum logic [1:0] {
        IDLE,
        RECV,
        FLUSH
    } dec_state_e;

    // log2 of the bytes per word, for a data width in bits
    function automatic int offset_bits_for(input int data_w);
        int bytes;
        int bits;
        bytes = data_w / 8;
        bits  = 0;
        while ((1 << bits) < bytes) begin
            bits++;
        end
        return bits;
    endfunction

endpackage

/* hdl/xfer_ctrl_if.sv */
`timescale 1ns/1ps

interface xfer_ctrl_if import align_pkg::*; #(
    parameter int DATA_W = 32
);

    localparam int OFF_W = offset_bits_for(DATA_W);

    logic [OFF_W-1:0] offset;         // Low address bits of the command
    logic             start;          // One cycle, command accepted
    logic             burst_last;     // Final beat is valid this cycle
    logic             transfer_last;
    beat_cnt_t        out_words;      // Aligned words owed to the stream
    logic [OFF_W:0]   last_bytes;     // 1 .. bytes per word

    modport ctrl (
        output offset, start, burst_last, transfer_last, out_words, last_bytes
    );

    modport align (
        input offset, start, burst_last, transfer_last
    );

    modport pack (
        input start, out_words, last_bytes
    );

endinterface

/* hdl/align_stream_if.sv */
`timescale 1ns/1ps

interface align_stream_if #(
    parameter int DATA_W = 32
);

    logic [DATA_W-1:0] data;
    logic              valid;
    logic              last_transfer;   // Flush word of the command
    logic              empty;           // Nothing to hand over this cycle

    modport src (
        output data, valid, last_transfer, empty
    );

    modport dst (
        input data, valid, last_transfer, empty
    );

endinterface

/* hdl/xfer_decode.sv */
`timescale 1ns/1ps

module xfer_decode import align_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_valid,
    input  byte_len_t cmd_addr,
    input  byte_len_t cmd_len,
    input  logic      beat_valid,
    output logic      busy,
    xfer_ctrl_if.ctrl ctrl
);

    localparam int BYTES = DATA_W / 8;
    localparam int OFF_W = offset_bits_for(DATA_W);
    localparam int SUM_W = LEN_W + 1;   // Room for offset plus length

    dec_state_e       state;
    beat_cnt_t        beats_left;
    logic             start_q;
    logic [OFF_W-1:0] offset_q;
    beat_cnt_t        out_words_q;
    logic [OFF_W:0]   last_bytes_q;

    logic [SUM_W-1:0] span_bytes;
    logic [SUM_W-1:0] owed_bytes;
    logic [OFF_W-1:0] len_rem;
    logic             final_beat;

    // Rounded up so the shift gives a ceiling
    assign span_bytes = SUM_W'(cmd_addr[OFF_W-1:0]) + SUM_W'(cmd_len) + SUM_W'(BYTES - 1);
    assign owed_bytes = SUM_W'(cmd_len) + SUM_W'(BYTES - 1);
    assign len_rem    = cmd_len[OFF_W-1:0];

    assign final_beat = (state == RECV) && beat_valid && (beats_left == beat_cnt_t'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            beats_left   <= '0;
            start_q      <= 1'b0;
            offset_q     <= '0;
            out_words_q  <= '0;
            last_bytes_q <= '0;
        end else begin
            start_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        offset_q    <= cmd_addr[OFF_W-1:0];
                        beats_left  <= beat_cnt_t'(span_bytes >> OFF_W);
                        out_words_q <= beat_cnt_t'(owed_bytes >> OFF_W);
                        // Whole-word length fills the final word
                        if (len_rem == '0)
                            last_bytes_q <= (OFF_W+1)'(BYTES);
                        else
                            last_bytes_q <= {1'b0, len_rem};
                        start_q <= 1'b1;
                        state   <= RECV;
                    end
                end
                RECV: begin
                    if (beat_valid) begin
                        beats_left <= beats_left - beat_cnt_t'(1);
                        if (final_beat)
                            state <= FLUSH;
                    end
                end
                FLUSH: state <= IDLE;   // Aligner drains its held beat here
                default: state <= IDLE;
            endcase
        end
    end

    assign busy = (state != IDLE);

    assign ctrl.offset        = offset_q;
    assign ctrl.start         = start_q;
    assign ctrl.burst_last    = final_beat;
    assign ctrl.transfer_last = final_beat;   // One burst per command
    assign ctrl.out_words     = out_words_q;
    assign ctrl.last_bytes    = last_bytes_q;

endmodule

/* hdl/burst_align.sv */
`timescale 1ns/1ps

module burst_align import align_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] beat_data,
    input  logic              beat_valid,
    xfer_ctrl_if.align        ctrl,
    align_stream_if.src       strm
);

    localparam int BYTES = DATA_W / 8;
    localparam int OFF_W = offset_bits_for(DATA_W);

    logic [DATA_W-1:0] held;         // Previous beat
    logic              held_valid;
    logic              flush;
    logic [DATA_W-1:0] shifted;

    // Upper bytes of the held beat, then lower bytes of the new one
    always_comb begin
        int src;
        for (int i = 0; i < BYTES; i++) begin
            src = i + int'(ctrl.offset);
            if (src < BYTES)
                shifted[8*i +: 8] = held[8*src +: 8];
            else
                shifted[8*i +: 8] = beat_data[8*(src-BYTES) +: 8];
        end
    end

    assign strm.data = shifted;

    // First beat of a command only fills the holding register
    assign strm.valid         = flush | (held_valid & beat_valid & ~ctrl.start);
    assign strm.last_transfer = flush;
    assign strm.empty         = ~strm.valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_valid <= 1'b0;
            flush      <= 1'b0;
        end else begin
            flush <= ctrl.burst_last & ctrl.transfer_last;   // Drain next cycle
            if (ctrl.start)
                held_valid <= 1'b0;
            if (beat_valid)
                held_valid <= 1'b1;   // Beat wins over start
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid)
            held <= beat_data;
    end

    // Offset width has to cover every lane position
    initial begin
        if ((1 << OFF_W) != BYTES)
            $error("burst_align: DATA_W %0d is not a power-of-two byte width", DATA_W);
    end

endmodule

/* hdl/align_packer.sv */
`timescale 1ns/1ps

module align_packer import align_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic                clk,
    input  logic                rst,
    align_stream_if.dst         strm,
    xfer_ctrl_if.pack           ctrl,
    output logic [DATA_W-1:0]   out_data,
    output logic [DATA_W/8-1:0] out_strb,
    output logic                out_valid,
    output logic                out_last
);

    localparam int BYTES = DATA_W / 8;

    beat_cnt_t        word_cnt;     // Words emitted for this command
    logic             closed;       // Flush seen, drop anything else
    logic             keep;
    logic             is_last;
    logic [BYTES-1:0] last_mask;

    // Surplus flush word fails the count check
    assign keep    = ~strm.empty & ~closed & (word_cnt < ctrl.out_words);
    assign is_last = keep & ((word_cnt + beat_cnt_t'(1)) == ctrl.out_words);

    // Low last_bytes lanes of the final word
    always_comb begin
        for (int i = 0; i < BYTES; i++) begin
            last_mask[i] = (i < int'(ctrl.last_bytes));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_cnt  <= '0;
            closed    <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            out_strb  <= '1;
        end else begin
            out_valid <= keep;
            out_last  <= is_last;
            out_strb  <= is_last ? last_mask : '1;   // Full strobe otherwise

            if (ctrl.start) begin
                word_cnt <= '0;
                closed   <= 1'b0;
            end else begin
                if (keep)
                    word_cnt <= word_cnt + beat_cnt_t'(1);
                if (strm.valid && strm.last_transfer)
                    closed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keep)
            out_data <= strm.data;
    end

endmodule

/* hdl/dma_read_align.sv */
`timescale 1ns/1ps

module dma_read_align import align_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  byte_len_t           cmd_addr,
    input  byte_len_t           cmd_len,
    input  logic [DATA_W-1:0]   beat_data,
    input  logic                beat_valid,
    output logic                busy,
    output logic [DATA_W-1:0]   out_data,
    output logic [DATA_W/8-1:0] out_strb,
    output logic                out_valid,
    output logic                out_last
);

    // Per-command control from decode
    xfer_ctrl_if #(.DATA_W(DATA_W)) ctrl_bus ();

    // Aligned words into the packer
    align_stream_if #(.DATA_W(DATA_W)) strm_bus ();

    xfer_decode #(
        .DATA_W (DATA_W)
    ) u_decode (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_addr   (cmd_addr),
        .cmd_len    (cmd_len),
        .beat_valid (beat_valid),
        .busy       (busy),
        .ctrl       (ctrl_bus.ctrl)
    );

    burst_align #(
        .DATA_W (DATA_W)
    ) u_align (
        .clk        (clk),
        .rst        (rst),
        .beat_data  (beat_data),
        .beat_valid (beat_valid),
        .ctrl       (ctrl_bus.align),
        .strm       (strm_bus.src)
    );

    align_packer #(
        .DATA_W (DATA_W)
    ) u_packer (
        .clk       (clk),
        .rst       (rst),
        .strm      (strm_bus.dst),
        .ctrl      (ctrl_bus.pack),
        .out_data  (out_data),
        .out_strb  (out_strb),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

endmodule

/* tb/dma_read_align_props.sv */
`timescale 1ns/1ps

module dma_read_align_props #(
    parameter int DATA_W = 32
) (
    input logic                clk,
    input logic                rst,
    input logic                cmd_valid,
    input logic                busy,
    input logic                out_valid,
    input logic                out_last,
    input logic [DATA_W/8-1:0] out_strb
);

    a_last_needs_valid: assert property (@(posedge clk) disable iff (rst)
        out_last |-> out_valid)
        else $error("out_last raised without out_valid");

    a_strb_full: assert property (@(posedge clk) disable iff (rst)
        !out_last |-> (out_strb == '1))
        else $error("partial strobe on a word that is not last");

    // A new command only starts from idle
    a_start_from_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(cmd_valid && !busy))
        else $error("command started while busy");

    a_cmd_taken: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid && !busy) |=> busy)
        else $error("idle command was not accepted");

    // Busy falls two cycles after the last beat, final word lands there or one earlier
    a_last_timing: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> (out_last || $past(out_last)))
        else $error("final word not seen at the end of the command");

endmodule

bind dma_read_align dma_read_align_props #(.DATA_W(DATA_W)) u_props (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .busy      (busy),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_strb  (out_strb)
);

/* tb/tb_dma_read_align.sv */
`timescale 1ns/1ps

module tb_dma_read_align import align_pkg::*;;

    localparam int DATA_W   = 32;
    localparam int BYTES    = DATA_W / 8;
    localparam int MAX_CMDS = 64;
    localparam int TIMEOUT  = 500;   // Cycles per wait

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    byte_len_t         cmd_addr;
    byte_len_t         cmd_len;
    logic [DATA_W-1:0] beat_data;
    logic              beat_valid;
    logic              busy;
    logic [DATA_W-1:0] out_data;
    logic [BYTES-1:0]  out_strb;
    logic              out_valid;
    logic              out_last;

    logic [15:0] stim [0:4*MAX_CMDS-1];   // Raw fields from the input file
    int c_addr [MAX_CMDS];
    int c_len [MAX_CMDS];
    int c_gap [MAX_CMDS];
    int c_words [MAX_CMDS];
    int last_beat_cyc [MAX_CMDS];   // Cycle the final beat was driven
    int n_cmds;
    int head;                       // Command whose words are arriving
    int word_idx;
    int word_total;
    int err_cnt;
    int cyc;
    logic timed_out;

    dma_read_align #(.DATA_W(DATA_W)) dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_addr   (cmd_addr),
        .cmd_len    (cmd_len),
        .beat_data  (beat_data),
        .beat_valid (beat_valid),
        .busy       (busy),
        .out_data   (out_data),
        .out_strb   (out_strb),
        .out_valid  (out_valid),
        .out_last   (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Memory contents
    function automatic logic [7:0] mem_byte(input int a);
        return 8'((a * 7 + 3) % 256);
    endfunction

    function automatic logic [DATA_W-1:0] beat_word(input int a);
        logic [DATA_W-1:0] w;
        for (int i = 0; i < BYTES; i++) begin
            w[8*i +: 8] = mem_byte(a + i);   // Little-endian lanes
        end
        return w;
    endfunction

    task automatic load_commands();
        $readmemh("tb/align_input.txt", stim);
        n_cmds = 0;
        while (n_cmds < MAX_CMDS && stim[4*n_cmds+1] != 16'h0) begin
            c_addr[n_cmds]  = int'(stim[4*n_cmds]);
            c_len[n_cmds]   = int'(stim[4*n_cmds+1]);
            c_gap[n_cmds]   = int'(stim[4*n_cmds+2]);
            c_words[n_cmds] = int'(stim[4*n_cmds+3]);
            n_cmds++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("Timeout: busy stayed high for %0d cycles at %0t", TIMEOUT, $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_command(input int n);
        int beats;
        int base_a;
        int gap;
        wait_idle();
        if (!timed_out) begin
            base_a = c_addr[n] - (c_addr[n] % BYTES);
            beats  = (c_addr[n] % BYTES + c_len[n] + BYTES - 1) / BYTES;
            cmd_valid = 1'b1;
            cmd_addr  = byte_len_t'(c_addr[n]);
            cmd_len   = byte_len_t'(c_len[n]);
            @(negedge clk);
            cmd_valid = 1'b0;
            for (int k = 0; k < beats; k++) begin
                if (c_gap[n] != 0 && k > 0) begin
                    gap = int'($urandom % 4);
                    repeat (gap) @(negedge clk);
                end
                beat_valid = 1'b1;
                beat_data  = beat_word(base_a + BYTES * k);
                if (k == beats - 1)
                    last_beat_cyc[n] = cyc;
                @(negedge clk);
                beat_valid = 1'b0;
            end
            // Stray command in FLUSH, the decoder has to ignore it
            cmd_valid = 1'b1;
            cmd_addr  = byte_len_t'(c_addr[n] + 1);
            cmd_len   = byte_len_t'(c_len[n] + 5);
            assert (busy) else begin
                $display("ERROR %0t: cmd %0d busy low right after the last beat", $time, n);
                err_cnt++;
            end
            @(negedge clk);
            cmd_valid = 1'b0;
            assert (!busy) else begin
                $display("ERROR %0t: cmd %0d busy still high one cycle after FLUSH", $time, n);
                err_cnt++;
            end
        end
    endtask

    task automatic check_output_word();
        int words;
        int lbytes;
        int beats;
        int delay;
        logic is_final;
        logic [BYTES-1:0] exp_strb;
        logic [7:0] exp_b;
        words    = c_words[head];
        is_final = (word_idx == words - 1);
        lbytes   = c_len[head] - BYTES * (words - 1);
        for (int i = 0; i < BYTES; i++) begin
            exp_strb[i] = is_final ? (i < lbytes) : 1'b1;
        end
        assert (out_last == is_final) else begin
            $display("ERROR %0t: cmd %0d word %0d out_last %0b", $time, head, word_idx, out_last);
            err_cnt++;
        end
        assert (out_strb == exp_strb) else begin
            $display("ERROR %0t: cmd %0d word %0d strobe %h, expected %h",
                     $time, head, word_idx, out_strb, exp_strb);
            err_cnt++;
        end
        for (int i = 0; i < BYTES; i++) begin
            exp_b = mem_byte(c_addr[head] + BYTES * word_idx + i);
            assert (!exp_strb[i] || out_data[8*i +: 8] == exp_b) else begin
                $display("ERROR %0t: cmd %0d word %0d lane %0d is %h, expected %h",
                         $time, head, word_idx, i, out_data[8*i +: 8], exp_b);
                err_cnt++;
            end
        end
        if (is_final) begin
            // Flush word is the final one unless it is surplus
            beats = (c_addr[head] % BYTES + c_len[head] + BYTES - 1) / BYTES;
            delay = (beats > words) ? 1 : 2;
            assert (cyc - last_beat_cyc[head] == delay) else begin
                $display("ERROR %0t: cmd %0d final word %0d cycles after last beat, expected %0d",
                         $time, head, cyc - last_beat_cyc[head], delay);
                err_cnt++;
            end
            head++;
            word_idx = 0;
        end else begin
            word_idx++;
        end
        word_total++;
    endtask

    always @(negedge clk) begin
        if (!rst && out_valid) begin
            assert (head < n_cmds) else begin
                $display("ERROR %0t: output word with no command outstanding", $time);
                err_cnt++;
            end
            if (head < n_cmds)
                check_output_word();
        end
    end

    task automatic wait_drain();
        int n;
        n = 0;
        while (head < n_cmds && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (head < n_cmds) begin
            $display("Timeout: only %0d of %0d commands completed", head, n_cmds);
            timed_out = 1'b1;
        end
        repeat (4) @(negedge clk);   // Catch stray words
    endtask

    initial begin
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_addr   = '0;
        cmd_len    = '0;
        beat_data  = '0;
        beat_valid = 1'b0;
        cyc        = 0;
        head       = 0;
        word_idx   = 0;
        word_total = 0;
        err_cnt    = 0;
        timed_out  = 1'b0;
        void'($urandom(65));
        load_commands();
        assert (n_cmds > 0) else begin
            $display("ERROR %0t: no commands read from the input file", $time);
            err_cnt++;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_cmds && !timed_out; i++) begin
            send_command(i);
        end
        if (!timed_out)
            wait_drain();
        $display("Errors: %0d, words checked: %0d, commands: %0d of %0d",
                 err_cnt, word_total, head, n_cmds);
        if (err_cnt == 0 && !timed_out)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* dma_read_align.f */
hdl/align_pkg.sv
hdl/xfer_ctrl_if.sv
hdl/align_stream_if.sv
hdl/xfer_decode.sv
hdl/burst_align.sv
hdl/align_packer.sv
hdl/dma_read_align.sv
tb/dma_read_align_props.sv
tb/tb_dma_read_align.sv

/* Makefile */
# Verilator build and run for the read-side aligner testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_read_align
FLIST     ?= dma_read_align.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/align_input.txt */
// One command per line, all fields hex: address length gap_mode expected_words
// gap_mode 0 sends beats back to back, 1 puts random idle cycles between beats
0000 0004 0 0001
0010 0010 0 0004
0020 0020 0 0008
0101 0007 0 0002
0102 000d 0 0004
0203 0009 0 0003
0301 0003 0 0001
0403 0002 0 0001
0502 0006 0 0002
0803 000a 0 0003
0902 0001 0 0001
0a01 000e 1 0004
0b03 000f 1 0004
0c00 000c 1 0003
0d02 0003 1 0001
1ffd 0040 1 0010
2000 0005 0 0002
// Zero length ends the list
0000 0000 0 0000
